/* verilog/mem_agent_pkg.sv */
// Package: widths, memory types, opcodes, atomic codes, FSM states, command union, helpers
`default_nettype none

package mem_agent_pkg;

   // ####################
   // Widths and sizes
   // ####################
   localparam int aw         = 32;
   localparam int cw         = 32;
   localparam int req_dw     = 256;               // 32 request bytes
   localparam int mem_dw     = 64;
   localparam int ram_words  = 64;
   localparam int word_aw    = $clog2(ram_words); // Address bits 8..3
   localparam int word_bytes = mem_dw / 8;
   localparam int lane_w     = $clog2(word_bytes); // Address bits 2..0
   localparam int req_ow     = $clog2(req_dw / 8); // Byte offset into request data
   localparam int bcnt_w     = 16;                 // Byte counts and offsets

   typedef logic [aw-1:0]     addr_t;
   typedef logic [mem_dw-1:0] mem_word_t;
   typedef logic [req_dw-1:0] req_data_t;
   typedef logic [7:0]        byte_mask_t;

   // Request and response opcodes
   localparam logic [4:0] op_read       = 5'd1;
   localparam logic [4:0] op_resp_read  = 5'd2;
   localparam logic [4:0] op_write      = 5'd3;
   localparam logic [4:0] op_resp_write = 5'd4;
   localparam logic [4:0] op_atomic     = 5'd9;

   // Agent FSM states
   localparam logic [2:0] st_idle      = 3'd0;
   localparam logic [2:0] st_access    = 3'd1;
   localparam logic [2:0] st_read_wait = 3'd2;
   localparam logic [2:0] st_rmw       = 3'd3;
   localparam logic [2:0] st_respond   = 3'd4;

   typedef enum logic [7:0] {
      at_add  = 8'd0,
      at_and  = 8'd1,
      at_or   = 8'd2,
      at_xor  = 8'd3,
      at_max  = 8'd4, // Signed
      at_min  = 8'd5,
      at_maxu = 8'd6, // Unsigned
      at_minu = 8'd7,
      at_swap = 8'd8
   } atype_e;

   // ####################
   // Command word
   // ####################
   typedef union packed {
      struct packed {
         logic [cw-17:0] rsvd;
         logic [7:0]     len;    // Beats minus one at the given size
         logic [2:0]     size;
         logic [4:0]     opcode;
      } xfer;
      struct packed {
         logic [cw-17:0] rsvd;
         atype_e         atype;  // Shares the len field
         logic [2:0]     size;
         logic [4:0]     opcode;
      } amo;
   } cmd_u;

   // Total bytes of a read or write
   function automatic logic [bcnt_w-1:0] xfer_bytes(cmd_u cmd);
      return (bcnt_w'(cmd.xfer.len) + bcnt_w'(1)) << cmd.xfer.size;
   endfunction

   function automatic cmd_u make_resp_cmd(logic [4:0] opcode, logic [lane_w:0] count);
      cmd_u resp;
      resp             = '0;
      resp.xfer.opcode = opcode;
      resp.xfer.size   = 3'd0; // Byte granularity
      resp.xfer.len    = 8'(count) - 8'd1;
      return resp;
   endfunction

endpackage

`default_nettype wire

/* verilog/agent_ifs.sv */
// Interfaces beat_if (beat sequencing) and mem_if (SRAM access), with modports
`timescale 1ns/1ps
`default_nettype none

interface beat_if;
   import mem_agent_pkg::*;

   logic              load;        // Start of a request
   addr_t             start_addr;
   logic [bcnt_w-1:0] total_bytes;
   logic              step;        // Current beat finished
   addr_t             addr;        // Current beat address
   logic [lane_w:0]   beat_bytes;  // 1 to 8
   logic [bcnt_w-1:0] offset;      // Bytes already done
   logic              last;

   modport user (output load, start_addr, total_bytes, step,
                 input  addr, beat_bytes, offset, last);
   modport counter (input  load, start_addr, total_bytes, step,
                    output addr, beat_bytes, offset, last);
endinterface

interface mem_if (input logic clk);
   import mem_agent_pkg::*;

   logic               we;
   logic [word_aw-1:0] addr;
   byte_mask_t         wmask;
   mem_word_t          wrdata;
   mem_word_t          rddata;     // One cycle after addr

   modport ctrl (input clk, rddata, output we, addr, wmask, wrdata);
   modport ram (input we, addr, wmask, wrdata, output rddata);
endinterface

`default_nettype wire

/* verilog/beat_counter.sv */
// Module beat_counter: splits a request into beats inside one memory word
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
   input logic     clk,
   input logic     nreset,
   beat_if.counter beat
);
   import mem_agent_pkg::*;

   addr_t             cur_addr;
   logic [bcnt_w-1:0] remaining;
   logic [bcnt_w-1:0] offset;
   logic [lane_w:0]   to_boundary;
   logic [lane_w:0]   beat_bytes;

   // Distance to the next 8-byte boundary
   assign to_boundary = word_bytes[lane_w:0] - {1'b0, cur_addr[lane_w-1:0]};

   assign beat_bytes = (remaining < bcnt_w'(to_boundary)) ? remaining[lane_w:0] : to_boundary;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cur_addr  <= '0;
         remaining <= '0;
         offset    <= '0;
      end else if (beat.load) begin
         cur_addr  <= beat.start_addr;
         remaining <= beat.total_bytes;
         offset    <= '0;
      end else if (beat.step) begin
         cur_addr  <= cur_addr + aw'(beat_bytes);
         offset    <= offset + bcnt_w'(beat_bytes);
         remaining <= remaining - bcnt_w'(beat_bytes);
      end
   end

   assign beat.addr       = cur_addr;
   assign beat.beat_bytes = beat_bytes;
   assign beat.offset     = offset;
   assign beat.last       = (remaining == bcnt_w'(beat_bytes)); // Final beat of request

   // ####################
   // Checks
   // ####################
   a_beat_size: assert property (@(posedge clk) disable iff (!nreset)
      remaining != '0 |-> beat_bytes >= 1 && beat_bytes <= word_bytes);

   // FSM must not step past the end of a request
   a_step_live: assert property (@(posedge clk) disable iff (!nreset)
      beat.step |-> remaining != '0);

endmodule

`default_nettype wire

/* verilog/agent_fsm.sv */
// Module agent_fsm: request capture, beat sequencing, atomic cycles, response handshake
`timescale 1ns/1ps
`default_nettype none

module agent_fsm (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     req_valid,
   input  mem_agent_pkg::cmd_u      req_cmd,
   input  mem_agent_pkg::addr_t     req_dstaddr,
   input  mem_agent_pkg::addr_t     req_srcaddr,
   input  mem_agent_pkg::req_data_t req_data,
   output logic                     req_ready,
   output logic                     resp_valid,
   output mem_agent_pkg::cmd_u      resp_cmd,
   output mem_agent_pkg::addr_t     resp_dstaddr,
   output mem_agent_pkg::addr_t     resp_srcaddr,
   output mem_agent_pkg::mem_word_t resp_data,
   input  logic                     resp_ready,
   input  mem_agent_pkg::mem_word_t rd_aligned,
   input  mem_agent_pkg::mem_word_t amo_result,
   output logic                     access,
   output logic                     rmw_write,
   output mem_agent_pkg::mem_word_t amo_operand,
   output mem_agent_pkg::atype_e    amo_type,
   output logic [2:0]               amo_size,
   output mem_agent_pkg::req_data_t wr_data,
   beat_if.user                     beat
);
   import mem_agent_pkg::*;

   logic [2:0] state;
   cmd_u       cmd_r;
   addr_t      srcaddr_r;
   req_data_t  data_r;
   logic       is_write;
   logic       is_atomic;

   assign is_write  = (cmd_r.xfer.opcode == op_write);
   assign is_atomic = (cmd_r.amo.opcode == op_atomic);

   // ####################
   // Request side
   // ####################
   assign req_ready        = (state == st_idle);
   assign beat.load        = req_valid && req_ready;
   assign beat.start_addr  = req_dstaddr;
   assign beat.total_bytes = (req_cmd.amo.opcode == op_atomic) ?
                             (bcnt_w'(1) << req_cmd.amo.size) : xfer_bytes(req_cmd);
   assign beat.step        = (state == st_respond) && resp_ready;

   // Strobes and operands for the datapath
   assign access      = (state == st_access) && is_write; // Store of a write beat
   assign rmw_write   = (state == st_rmw);                // Atomic write-back
   assign amo_operand = data_r[mem_dw-1:0];
   assign amo_type    = cmd_r.amo.atype;
   assign amo_size    = cmd_r.amo.size;
   assign wr_data     = data_r;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state      <= st_idle;
         resp_valid <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (beat.load) state <= st_access;
            end
            st_access: state <= st_read_wait; // SRAM read or write this cycle
            st_read_wait: begin
               state      <= is_atomic ? st_rmw : st_respond;
               resp_valid <= !is_atomic;
            end
            st_rmw: begin
               state      <= st_respond;
               resp_valid <= 1'b1;
            end
            st_respond: begin
               if (resp_ready) begin
                  resp_valid <= 1'b0;
                  state      <= beat.last ? st_idle : st_access;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Request capture and response fields
   always_ff @(posedge clk) begin
      if (beat.load) begin
         cmd_r     <= req_cmd;
         srcaddr_r <= req_srcaddr;
         data_r    <= req_data;
      end
      if (state == st_read_wait) begin // Old value also kept here for atomics
         resp_cmd     <= make_resp_cmd(is_write ? op_resp_write : op_resp_read,
                                       beat.beat_bytes);
         resp_dstaddr <= srcaddr_r + aw'(beat.offset);
         resp_srcaddr <= beat.addr;
         resp_data    <= is_write ? '0 : rd_aligned;
      end
   end

   // ####################
   // Checks
   // ####################
   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_cmd) &&
         $stable(resp_dstaddr) && $stable(resp_srcaddr) && $stable(resp_data));

endmodule

`default_nettype wire

/* verilog/lane_align.sv */
// Module lane_align: byte masks, lane-shifted write data, right-aligned read data
`timescale 1ns/1ps
`default_nettype none

module lane_align (
   input  logic                     access,
   input  logic                     rmw_write,
   input  mem_agent_pkg::req_data_t wr_data,
   input  mem_agent_pkg::mem_word_t amo_result,
   input  logic [2:0]               amo_size,
   output mem_agent_pkg::mem_word_t rd_aligned,
   beat_if.user                     beat,
   mem_if.ctrl                      mem
);
   import mem_agent_pkg::*;

   logic [lane_w-1:0] lane;
   logic [lane_w-1:0] lane_r;    // Lane of the word now on rddata
   byte_mask_t        beat_mask;
   byte_mask_t        amo_mask;
   mem_word_t         wr_slice;
   mem_word_t         rd_shift;

   assign lane = beat.addr[lane_w-1:0];

   // Masks start at the beat lane
   assign beat_mask = byte_mask_t'(((16'd1 << beat.beat_bytes) - 16'd1) << lane);
   assign amo_mask  = byte_mask_t'(((16'd1 << (4'd1 << amo_size)) - 16'd1) << lane);

   // Request bytes of this beat, moved to lane 0
   assign wr_slice = mem_word_t'(wr_data >> {beat.offset[req_ow-1:0], 3'b000});

   assign mem.we     = access | rmw_write;
   assign mem.addr   = beat.addr[lane_w +: word_aw];
   assign mem.wmask  = rmw_write ? amo_mask : beat_mask;
   assign mem.wrdata = rmw_write ? (amo_result << {lane, 3'b000}) :
                                   (wr_slice << {lane, 3'b000});

   always_ff @(posedge mem.clk) begin
      lane_r <= lane;
   end

   assign rd_shift = mem.rddata >> {lane_r, 3'b000};

   // Bytes beyond the beat read as zero
   always_comb begin
      for (int i = 0; i < word_bytes; i++) begin
         rd_aligned[i*8 +: 8] = (i < beat.beat_bytes) ? rd_shift[i*8 +: 8] : 8'h00;
      end
   end

   a_wmask_set: assert property (@(posedge mem.clk)
      mem.we |-> mem.wmask != '0);

endmodule

`default_nettype wire

/* verilog/atomic_alu.sv */
// Module atomic_alu: atomic operation on the low operand-size bytes
`timescale 1ns/1ps
`default_nettype none

module atomic_alu (
   input  mem_agent_pkg::atype_e    amo_type,
   input  logic [2:0]               amo_size,
   input  mem_agent_pkg::mem_word_t amo_operand,
   input  mem_agent_pkg::mem_word_t rd_aligned,
   output mem_agent_pkg::mem_word_t amo_result
);
   import mem_agent_pkg::*;

   mem_word_t keep;      // Bits inside the operand size
   mem_word_t top_bit;   // Sign bit at that size
   mem_word_t op_new;
   mem_word_t op_old;
   mem_word_t sx_new;
   mem_word_t sx_old;
   logic      new_gt_s;
   logic      new_gt_u;
   mem_word_t raw;

   assign keep = (amo_size >= 3'd3) ? '1 :
                 (mem_word_t'(1) << (8 << amo_size)) - mem_word_t'(1);
   assign top_bit = keep & ~(keep >> 1);

   assign op_new = amo_operand & keep;
   assign op_old = rd_aligned & keep;

   // Sign-extend both to the full word for signed compare
   assign sx_new = |(op_new & top_bit) ? (op_new | ~keep) : op_new;
   assign sx_old = |(op_old & top_bit) ? (op_old | ~keep) : op_old;

   assign new_gt_s = $signed(sx_new) > $signed(sx_old);
   assign new_gt_u = op_new > op_old;

   always_comb begin
      case (amo_type)
         at_add:  raw = op_new + op_old;
         at_and:  raw = op_new & op_old;
         at_or:   raw = op_new | op_old;
         at_xor:  raw = op_new ^ op_old;
         at_max:  raw = new_gt_s ? op_new : op_old;
         at_min:  raw = new_gt_s ? op_old : op_new;
         at_maxu: raw = new_gt_u ? op_new : op_old;
         at_minu: raw = new_gt_u ? op_old : op_new;
         default: raw = op_new; // Swap and unknown codes
      endcase
   end

   assign amo_result = raw & keep; // Drops add carry above the size

endmodule

`default_nettype wire

/* verilog/sram_sp.sv */
// Module sram_sp: single-port synchronous SRAM with per-byte write enable
`timescale 1ns/1ps
`default_nettype none

module sram_sp (
   input logic clk,
   mem_if.ram  mem
);
   import mem_agent_pkg::*;

   mem_word_t ram [ram_words];

   // Registered read returns the contents before a same-cycle write
   always_ff @(posedge clk) begin
      mem.rddata <= ram[mem.addr];
      for (int i = 0; i < word_bytes; i++) begin
         if (mem.we && mem.wmask[i]) begin
            ram[mem.addr][i*8 +: 8] <= mem.wrdata[i*8 +: 8];
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/mem_agent.sv */
// Module mem_agent: memory agent top level with plain device ports
`timescale 1ns/1ps
`default_nettype none

module mem_agent (
   input  logic                     clk,
   input  logic                     nreset,
   // Request channel
   input  logic                     req_valid,
   input  mem_agent_pkg::cmd_u      req_cmd,
   input  mem_agent_pkg::addr_t     req_dstaddr,
   input  mem_agent_pkg::addr_t     req_srcaddr,
   input  mem_agent_pkg::req_data_t req_data,
   output logic                     req_ready,
   // Response channel
   output logic                     resp_valid,
   output mem_agent_pkg::cmd_u      resp_cmd,
   output mem_agent_pkg::addr_t     resp_dstaddr,
   output mem_agent_pkg::addr_t     resp_srcaddr,
   output mem_agent_pkg::mem_word_t resp_data,
   input  logic                     resp_ready
);
   import mem_agent_pkg::*;

   mem_word_t  rd_aligned;
   mem_word_t  amo_result;
   mem_word_t  amo_operand;
   atype_e     amo_type;
   logic [2:0] amo_size;
   req_data_t  wr_data;
   logic       access;
   logic       rmw_write;

   beat_if u_beat ();
   mem_if  u_mem (.clk(clk));

   // ####################
   // Control
   // ####################
   agent_fsm u_fsm (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .rd_aligned   (rd_aligned),
      .amo_result   (amo_result),
      .access       (access),
      .rmw_write    (rmw_write),
      .amo_operand  (amo_operand),
      .amo_type     (amo_type),
      .amo_size     (amo_size),
      .wr_data      (wr_data),
      .beat         (u_beat)
   );

   beat_counter u_beat_counter (
      .clk    (clk),
      .nreset (nreset),
      .beat   (u_beat)
   );

   // ####################
   // Datapath and memory
   // ####################
   lane_align u_lane_align (
      .access     (access),
      .rmw_write  (rmw_write),
      .wr_data    (wr_data),
      .amo_result (amo_result),
      .amo_size   (amo_size),
      .rd_aligned (rd_aligned),
      .beat       (u_beat),
      .mem        (u_mem)
   );

   atomic_alu u_atomic_alu (
      .amo_type    (amo_type),
      .amo_size    (amo_size),
      .amo_operand (amo_operand),
      .rd_aligned  (rd_aligned),
      .amo_result  (amo_result)
   );

   sram_sp u_sram (
      .clk (clk),
      .mem (u_mem)
   );

endmodule

`default_nettype wire

/* verification/tb_mem_agent.sv */
// Testbench for mem_agent: clock, reset, stimulus, reference memory model, response checks
`timescale 1ns/1ps
`default_nettype none

module tb_mem_agent;
   import mem_agent_pkg::*;

   logic      clk;
   logic      nreset;
   logic      req_valid;
   cmd_u      req_cmd;
   addr_t     req_dstaddr;
   addr_t     req_srcaddr;
   req_data_t req_data;
   logic      req_ready;
   logic      resp_valid;
   cmd_u      resp_cmd;
   addr_t     resp_dstaddr;
   addr_t     resp_srcaddr;
   mem_word_t resp_data;
   logic      resp_ready;

   integer     seed;
   int         err_count;
   int         cycles;
   int         cycle_limit;
   int         total_beats;
   int         cur_beats;     // Beats of the request now offered
   logic [7:0] ref_mem [512];

   // Planned requests
   cmd_u      st_cmd [$];
   addr_t     st_dst [$];
   addr_t     st_src [$];
   req_data_t st_data [$];

   // Expected response beats, oldest first
   cmd_u      exp_cmd_q [$];
   addr_t     exp_dst_q [$];
   addr_t     exp_src_q [$];
   mem_word_t exp_data_q [$];

   logic      held_valid;     // Response seen stalled last cycle
   cmd_u      held_cmd;
   addr_t     held_dst;
   addr_t     held_src;
   mem_word_t held_data;

   mem_agent dut (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ####################
   // Failure reporting
   // ####################
   task automatic fail_now(string why);
      err_count++;
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   task automatic check_cmd(string name, cmd_u got, cmd_u exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
   endtask

   task automatic check_addr(string name, addr_t got, addr_t exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
   endtask

   task automatic check_data(string name, mem_word_t got, mem_word_t exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED %s: got 0x%016h, expected 0x%016h", name, got, exp));
   endtask

   // ####################
   // Reference model
   // ####################
   function automatic int req_bytes(cmd_u c);
      if (c.amo.opcode == op_atomic)
         return 1 << c.amo.size;
      return (int'(c.xfer.len) + 1) << c.xfer.size;
   endfunction

   function automatic int count_beats(cmd_u c, addr_t d);
      int left;
      int lane;
      int n;
      int beats;
      left  = req_bytes(c);
      lane  = int'(d[2:0]);
      beats = 0;
      while (left > 0) begin
         n = 8 - lane;
         if (left < n) n = left;
         left  -= n;
         lane  = 0;      // Later beats start word aligned
         beats++;
      end
      return beats;
   endfunction

   function automatic mem_word_t amo_calc(atype_e t, logic [2:0] size, mem_word_t old_v,
                                          mem_word_t opnd);
      int        sh;
      mem_word_t mask;
      mem_word_t a;
      mem_word_t b;
      longint    sa;
      longint    sb;
      mem_word_t r;
      sh   = 64 - (8 << size);
      mask = {64{1'b1}} >> sh;
      a    = opnd & mask;
      b    = old_v & mask;
      sa   = $signed(a << sh) >>> sh;  // Sign extend from the operand size
      sb   = $signed(b << sh) >>> sh;
      case (t)
         at_add:  r = a + b;
         at_and:  r = a & b;
         at_or:   r = a | b;
         at_xor:  r = a ^ b;
         at_max:  r = (sa > sb) ? a : b;
         at_min:  r = (sa < sb) ? a : b;
         at_maxu: r = (a > b) ? a : b;
         at_minu: r = (a < b) ? a : b;
         default: r = a;
      endcase
      return r & mask;
   endfunction

   // Applies one request to the model and queues its response beats
   function automatic int model_request(cmd_u c, addr_t dst, addr_t src, req_data_t data);
      int        total;
      int        n;
      int        k;
      int        off;
      int        beats;
      addr_t     a;
      addr_t     ba;
      mem_word_t old_v;
      mem_word_t res;
      cmd_u      rc;
      logic      wr;
      logic      amo;
      amo   = (c.amo.opcode == op_atomic);
      wr    = (c.xfer.opcode == op_write);
      total = req_bytes(c);
      a     = dst;
      off   = 0;
      beats = 0;
      while (off < total) begin
         n = 8 - int'(a[2:0]);
         if (total - off < n) n = total - off;
         old_v = '0;
         for (k = 0; k < n; k++) begin
            ba = a + addr_t'(k);
            old_v[k*8 +: 8] = ref_mem[ba[8:0]];
         end
         if (amo) res = amo_calc(c.amo.atype, c.amo.size, old_v, data[63:0]);
         for (k = 0; k < n; k++) begin
            ba = a + addr_t'(k);
            if (amo) ref_mem[ba[8:0]] = res[k*8 +: 8];
            else if (wr) ref_mem[ba[8:0]] = data[(off+k)*8 +: 8];
         end
         rc             = '0;
         rc.xfer.opcode = wr ? op_resp_write : op_resp_read;
         rc.xfer.len    = 8'(n - 1);
         exp_cmd_q.push_back(rc);
         exp_dst_q.push_back(src + addr_t'(off));
         exp_src_q.push_back(a);
         exp_data_q.push_back(wr ? mem_word_t'(0) : old_v);
         a     += addr_t'(n);
         off   += n;
         beats++;
      end
      return beats;
   endfunction

   // ####################
   // Stimulus
   // ####################
   function automatic int rnd(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic addr_t rand_addr();
      return addr_t'($random(seed));
   endfunction

   function automatic req_data_t rand_data();
      req_data_t v;
      int        k;
      v = '0;
      for (k = 0; k < 8; k++) v = {v[223:0], 32'($random(seed))};
      return v;
   endfunction

   function automatic cmd_u xfer_cmd(logic [4:0] op, int size, int len);
      cmd_u c;
      c             = '0;
      c.xfer.opcode = op;
      c.xfer.size   = 3'(size);
      c.xfer.len    = 8'(len);
      return c;
   endfunction

   function automatic cmd_u amo_cmd(int t, int size);
      cmd_u c;
      c            = '0;
      c.amo.opcode = op_atomic;
      c.amo.size   = 3'(size);
      c.amo.atype  = atype_e'(8'(t));
      return c;
   endfunction

   task automatic add_req(cmd_u c, addr_t d, addr_t s, req_data_t x);
      st_cmd.push_back(c);
      st_dst.push_back(d);
      st_src.push_back(s);
      st_data.push_back(x);
      total_beats += count_beats(c, d);
   endtask

   task automatic build_stimulus();
      int        i;
      int        t;
      int        s;
      int        r;
      int        kind;
      int        len;
      int        sign_bit;
      addr_t     d;
      addr_t     src;
      addr_t     word_addr [8];
      mem_word_t init_v;
      mem_word_t opnd;
      req_data_t data;
      for (i = 0; i < 16; i++) begin     // Fill all 512 bytes
         data = rand_data();
         src  = rand_addr();
         add_req(xfer_cmd(op_write, 3, 3), addr_t'(i * 32), src, data);
      end
      for (i = 0; i < 8; i++) begin      // Aligned single beats
         word_addr[i] = addr_t'(rnd(64) * 8);
         src          = rand_addr();
         data         = rand_data();
         add_req(xfer_cmd(op_write, 3, 0), word_addr[i], src, data);
      end
      for (i = 0; i < 8; i++) begin
         src = rand_addr();
         add_req(xfer_cmd(op_read, 3, 0), word_addr[i], src, '0);
      end
      for (i = 0; i < 24; i++) begin     // Unaligned multi-beat
         s = rnd(4);
         len = rnd(32 >> s);
         if (i < 4) len = (32 >> s) - 1;
         d    = addr_t'(rnd(512));
         src  = rand_addr();
         data = rand_data();
         add_req(xfer_cmd(op_write, s, len), d, src, data);
         src = rand_addr();
         add_req(xfer_cmd(op_read, s, len), d, src, '0);
      end
      for (t = 0; t < 9; t++) begin
         for (s = 0; s < 4; s++) begin
            for (r = 0; r < 2; r++) begin
               d        = addr_t'(rnd(512)) & ~addr_t'((1 << s) - 1);
               init_v   = {32'($random(seed)), 32'($random(seed))};
               opnd     = {32'($random(seed)), 32'($random(seed))};
               sign_bit = (8 << s) - 1;
               init_v[sign_bit] = (r == 0); // Opposite signs both ways round
               opnd[sign_bit]   = (r != 0);
               src = rand_addr();
               add_req(xfer_cmd(op_write, s, 0), d, src, req_data_t'(init_v));
               src = rand_addr();
               add_req(amo_cmd(t, s), d, src, req_data_t'(opnd));
               src = rand_addr();
               add_req(xfer_cmd(op_read, s, 0), d, src, '0);
            end
         end
      end
      for (i = 0; i < 300; i++) begin    // Random mix
         kind = rnd(3);
         s    = rnd(4);
         len  = rnd(32 >> s);
         t    = rnd(9);
         d    = rand_addr();
         src  = rand_addr();
         data = rand_data();
         if (kind == 2)
            add_req(amo_cmd(t, s), d & ~addr_t'((1 << s) - 1), src, data);
         else
            add_req(xfer_cmd((kind == 0) ? op_read : op_write, s, len), d, src, data);
      end
   endtask

   // Offers one request and holds it until accepted
   task automatic send_request(cmd_u c, addr_t dst, addr_t src, req_data_t data);
      cur_beats   = model_request(c, dst, src, data);
      req_cmd     = c;
      req_dstaddr = dst;
      req_srcaddr = src;
      req_data    = data;
      req_valid   = 1'b1;
      @(negedge clk);
      while (!req_ready) @(negedge clk);
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   // Random back-pressure, one draw per cycle
   initial begin
      forever begin
         @(posedge clk);
         #1;
         resp_ready = (($random(seed) & 3) != 0);
      end
   end

   // ####################
   // Compare
   // ####################
   task automatic compare_beat();
      if (exp_cmd_q.size() == 0) fail_now("A response arrived with no beat expected");
      check_cmd("resp_cmd", resp_cmd, exp_cmd_q.pop_front());
      check_addr("resp_dstaddr", resp_dstaddr, exp_dst_q.pop_front());
      check_addr("resp_srcaddr", resp_srcaddr, exp_src_q.pop_front());
      check_data("resp_data", resp_data, exp_data_q.pop_front());
   endtask

   // Values at the falling edge are those seen by the next rising edge
   always @(negedge clk) begin
      if (nreset) begin
         if (held_valid) begin
            check_flag("resp_valid", resp_valid, 1'b1);
            check_cmd("resp_cmd", resp_cmd, held_cmd);
            check_addr("resp_dstaddr", resp_dstaddr, held_dst);
            check_addr("resp_srcaddr", resp_srcaddr, held_src);
            check_data("resp_data", resp_data, held_data);
         end
         held_valid = resp_valid && !resp_ready;
         held_cmd   = resp_cmd;
         held_dst   = resp_dstaddr;
         held_src   = resp_srcaddr;
         held_data  = resp_data;
         if (resp_valid && resp_ready) compare_beat();
         if (req_valid && req_ready && exp_cmd_q.size() != cur_beats)
            fail_now("A request was accepted before the previous request had finished");
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit)
         fail_now($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
   end

   initial begin
      int i;
      seed        = 32'h65c5_3d0f;
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      resp_ready  = 1'b0;
      err_count   = 0;
      cycles      = 0;
      total_beats = 0;
      cur_beats   = 0;
      held_valid  = 1'b0;
      build_stimulus();
      cycle_limit = total_beats * 20 + 1000;
      repeat (5) @(posedge clk);
      #1;
      nreset = 1'b1;
      @(negedge clk);
      check_flag("req_ready", req_ready, 1'b1);
      check_flag("resp_valid", resp_valid, 1'b0);
      @(posedge clk);
      #1;
      for (i = 0; i < st_cmd.size(); i++) begin
         send_request(st_cmd[i], st_dst[i], st_src[i], st_data[i]);
      end
      while (exp_cmd_q.size() != 0) @(negedge clk);
      @(negedge clk);
      check_flag("req_ready", req_ready, 1'b1);
      check_flag("resp_valid", resp_valid, 1'b0);
      if (err_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
verilog/mem_agent_pkg.sv
verilog/agent_ifs.sv
verilog/beat_counter.sv
verilog/agent_fsm.sv
verilog/lane_align.sv
verilog/atomic_alu.sv
verilog/sram_sp.sv
verilog/mem_agent.sv
verification/tb_mem_agent.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mem_agent
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Result: FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
